/* bench/tb_ps2_kbd.sv */
`timescale 1ns/1ps

module tb_ps2_kbd;

    localparam int HALF_BIT = 10;  // clk cycles per PS/2 clock phase.
    localparam int WAIT_LIMIT = 400;
    localparam int RESET_CYCLES = 16;

    logic            clk;
    logic            rst_n;
    logic            ps2_clk;
    logic            ps2_data;
    logic            next_n;
    ps2_pkg::code_t  code;
    logic            ready;
    logic            overflow;
    ps2_pkg::seg_t   seg0;
    ps2_pkg::seg_t   seg1;
    ps2_pkg::seg_t   seg2;
    ps2_pkg::seg_t   seg3;
    ps2_pkg::seg_t   seg4;
    ps2_pkg::seg_t   seg5;

    logic [15:0]     lfsr;

    ps2_pkg::code_t  model_q[$];
    ps2_pkg::code_t  model_held;
    logic            model_held_valid;
    logic            model_pending;
    logic            model_key_up;
    ps2_pkg::count_t model_count;
    logic            model_overflow;

    ps2_kbd_top ps2_kbd_top_i (
        .clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .next_n(next_n),
        .code(code), .ready(ready), .overflow(overflow),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_code(input string name, input ps2_pkg::code_t actual,
                              input ps2_pkg::code_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_count(input string name, input ps2_pkg::count_t actual,
                               input ps2_pkg::count_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_seg(input string name, input ps2_pkg::seg_t actual,
                             input ps2_pkg::seg_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Every drive lands 2 ns after a rising edge.
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_code(output ps2_pkg::code_t value);
        int i;
        do begin
            for (i = 0; i < 8; i++) begin
                lfsr = lfsr_next(lfsr);
                value[i] = lfsr[0];
            end
        end while (value == ps2_pkg::BREAK_CODE);
    endtask

    // Start, eight data bits LSB first, odd parity, stop.
    task automatic send_byte(input ps2_pkg::code_t data, input logic bad_parity,
                             input logic bad_stop);
        logic [10:0] frame;
        int i;
        frame = {~bad_stop, ~^data ^ bad_parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        wait_cycles(HALF_BIT);
    endtask

    task automatic model_reset();
        model_q.delete();
        model_held_valid = 1'b0;
        model_held = 8'h00;
        model_pending = 1'b0;
        model_key_up = 1'b1;
        model_count = 8'd0;
        model_overflow = 1'b0;
    endtask

    task automatic model_byte(input ps2_pkg::code_t b);
        if (b == ps2_pkg::BREAK_CODE) begin
            model_pending = 1'b1;
        end else if (model_pending) begin
            model_pending = 1'b0;
            model_key_up = 1'b1;
            if (model_held_valid && model_held == b) begin
                model_held_valid = 1'b0;
            end
        end else begin
            if (model_q.size() < ps2_pkg::FIFO_DEPTH) begin
                model_q.push_back(b);
            end else begin
                model_overflow = 1'b1;  // Lost code.
            end
            model_key_up = 1'b0;
            if (!model_held_valid || model_held != b) begin
                model_count = model_count + 8'd1;
            end
            model_held = b;
            model_held_valid = 1'b1;
        end
    endtask

    function automatic ps2_pkg::seg_t expected_seg(input int idx);
        ps2_pkg::code_t head;
        logic show;
        show = (model_q.size() != 0) && !model_key_up;
        head = show ? model_q[0] : 8'h00;
        case (idx)
            0: return show ? ps2_pkg::hex_digit_seg(head[3:0]) : ps2_pkg::SEG_BLANK;
            1: return show ? ps2_pkg::hex_digit_seg(head[7:4]) : ps2_pkg::SEG_BLANK;
            2: return show ? ps2_pkg::dec_digit_seg(head % 8'd10) : ps2_pkg::SEG_BLANK;
            3: return show ? ps2_pkg::dec_digit_seg(head / 8'd10) : ps2_pkg::SEG_BLANK;
            4: return ps2_pkg::dec_digit_seg(model_count % 8'd10);
            default: return ps2_pkg::dec_digit_seg(model_count / 8'd10);
        endcase
    endfunction

    task automatic check_outputs();
        check_flag("ready", ready, model_q.size() != 0);
        check_flag("overflow", overflow, model_overflow);
        check_flag("key_up", ps2_kbd_top_i.key_up, model_key_up);
        check_count("press_count", ps2_kbd_top_i.press_count, model_count);
        if (model_q.size() != 0) begin
            check_code("code", code, model_q[0]);
        end
        check_seg("seg0", seg0, expected_seg(0));
        check_seg("seg1", seg1, expected_seg(1));
        check_seg("seg2", seg2, expected_seg(2));
        check_seg("seg3", seg3, expected_seg(3));
        check_seg("seg4", seg4, expected_seg(4));
        check_seg("seg5", seg5, expected_seg(5));
    endtask

    task automatic wait_for_ready(input logic level);
        int n;
        n = 0;
        while (ready !== level) begin
            if (n >= WAIT_LIMIT) begin
                if (level) begin
                    fail_now("ready never rose");
                end else begin
                    fail_now("ready never fell");
                end
            end
            wait_cycles(1);
            n++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        wait_cycles(RESET_CYCLES);
        rst_n = 1'b1;
        model_reset();
    endtask

    task automatic press_key(input ps2_pkg::code_t c);
        send_byte(c, 1'b0, 1'b0);
        model_byte(c);
        if (model_q.size() != 0) begin
            wait_for_ready(1'b1);
        end
        check_outputs();
    endtask

    task automatic release_key(input ps2_pkg::code_t c);
        send_byte(ps2_pkg::BREAK_CODE, 1'b0, 1'b0);
        model_byte(ps2_pkg::BREAK_CODE);
        send_byte(c, 1'b0, 1'b0);
        model_byte(c);
        check_outputs();
    endtask

    task automatic pop_key();
        wait_for_ready(1'b1);
        check_code("code", code, model_q[0]);
        next_n = 1'b0;
        wait_cycles(1);
        next_n = 1'b1;
        void'(model_q.pop_front());
        check_outputs();
    endtask

    task automatic drain_queue();
        while (model_q.size() != 0) begin
            pop_key();
        end
        wait_for_ready(1'b0);
        check_outputs();
    endtask

    initial begin
        ps2_pkg::code_t c;
        ps2_pkg::code_t c2;
        int i;
        clk = 1'b0;
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        next_n = 1'b1;
        lfsr = 16'd77;
        model_reset();
        apply_reset();
        check_outputs();

        for (i = 0; i < 6; i++) begin
            random_code(c);
            press_key(c);
        end
        drain_queue();

        // Break sequence leaves the queue alone and blanks the code digits.
        random_code(c);
        press_key(c);
        release_key(c);
        check_seg("seg0", seg0, ps2_pkg::SEG_BLANK);
        check_seg("seg1", seg1, ps2_pkg::SEG_BLANK);
        check_seg("seg2", seg2, ps2_pkg::SEG_BLANK);
        check_seg("seg3", seg3, ps2_pkg::SEG_BLANK);
        random_code(c2);
        press_key(c2);
        drain_queue();

        // Typematic repeats, then release and press again.
        random_code(c);
        press_key(c);
        press_key(c);
        press_key(c);
        release_key(c);
        press_key(c);
        drain_queue();

        random_code(c);
        press_key(c);
        random_code(c2);
        send_byte(c2, 1'b1, 1'b0);
        check_outputs();
        send_byte(c2, 1'b0, 1'b1);
        check_outputs();
        drain_queue();
        send_byte(c2, 1'b1, 1'b0);
        wait_cycles(HALF_BIT);
        check_outputs();

        // Nine codes into eight entries.
        for (i = 0; i < 9; i++) begin
            random_code(c);
            press_key(c);
        end
        check_flag("overflow", overflow, 1'b1);
        drain_queue();

        random_code(c);
        press_key(c);
        apply_reset();
        check_flag("ready", ready, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_seg("seg4", seg4, ps2_pkg::dec_digit_seg(8'd0));
        check_seg("seg5", seg5, ps2_pkg::dec_digit_seg(8'd0));
        check_outputs();
        random_code(c);
        press_key(c);
        drain_queue();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the PS/2 keyboard testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_ps2_kbd -o tb_ps2_kbd

./obj_dir/tb_ps2_kbd > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi

/* sim.f */
src/ps2_pkg.sv
src/ps2_rx.sv
src/key_tracker.sv
src/scan_fifo.sv
src/seg_display.sv
src/ps2_kbd_top.sv
bench/tb_ps2_kbd.sv

/* src/key_tracker.sv */
`timescale 1ns/1ps

module key_tracker (
    input  logic             clk,
    input  logic             rst_n,
    input  ps2_pkg::code_t   rx_code,
    input  logic             rx_valid,
    output logic             push,
    output ps2_pkg::code_t   push_code,
    output logic             key_up,
    output ps2_pkg::count_t  press_count
);

    logic            pending;
    logic            held_valid;
    ps2_pkg::code_t  held_key;
    logic            new_press;

    // A repeat of the held key is typematic, not a new press.
    assign new_press = !held_valid || (held_key != rx_code);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending     <= 1'b0;
            held_valid  <= 1'b0;
            key_up      <= 1'b1;
            press_count <= '0;
            push        <= 1'b0;
        end else begin
            push <= 1'b0;
            if (rx_valid) begin
                if (rx_code == ps2_pkg::BREAK_CODE) begin
                    pending <= 1'b1;
                end else if (pending) begin
                    pending <= 1'b0;  // Released key code.
                    key_up  <= 1'b1;
                    if (held_valid && held_key == rx_code) begin
                        held_valid <= 1'b0;
                    end
                end else begin
                    push       <= 1'b1;
                    key_up     <= 1'b0;
                    held_valid <= 1'b1;
                    if (new_press) begin
                        press_count <= press_count + 8'd1;  // Wraps at 256.
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && !pending && rx_code != ps2_pkg::BREAK_CODE) begin
            push_code <= rx_code;
            held_key  <= rx_code;
        end
    end

endmodule

/* src/ps2_kbd_top.sv */
`timescale 1ns/1ps

module ps2_kbd_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ps2_clk,
    input  logic            ps2_data,
    input  logic            next_n,
    output ps2_pkg::code_t  code,
    output logic            ready,
    output logic            overflow,
    output ps2_pkg::seg_t   seg0,
    output ps2_pkg::seg_t   seg1,
    output ps2_pkg::seg_t   seg2,
    output ps2_pkg::seg_t   seg3,
    output ps2_pkg::seg_t   seg4,
    output ps2_pkg::seg_t   seg5
);

    ps2_pkg::code_t   rx_code;
    logic             rx_valid;
    logic             push;
    ps2_pkg::code_t   push_code;
    logic             key_up;
    ps2_pkg::count_t  press_count;

    ps2_rx ps2_rx_i (
        .clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .rx_code(rx_code), .rx_valid(rx_valid)
    );

    key_tracker key_tracker_i (
        .clk(clk), .rst_n(rst_n), .rx_code(rx_code), .rx_valid(rx_valid),
        .push(push), .push_code(push_code), .key_up(key_up), .press_count(press_count)
    );

    scan_fifo scan_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(push), .push_code(push_code), .next_n(next_n),
        .head_code(code), .ready(ready), .overflow(overflow)
    );

    seg_display seg_display_i (
        .head_code(code), .ready(ready), .key_up(key_up), .press_count(press_count),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5)
    );

endmodule

/* src/ps2_pkg.sv */
package ps2_pkg;

    typedef logic [7:0] code_t;
    typedef logic [7:0] count_t;
    typedef logic [6:0] seg_t;  // Active low, a..g from bit 6 down.
    typedef logic [3:0] ptr_t;

    localparam code_t BREAK_CODE = 8'hF0;
    localparam int FIFO_DEPTH = 8;
    localparam seg_t SEG_BLANK = 7'b1111111;

    function automatic seg_t hex_digit_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'hA: return 7'b0001000;
            4'hB: return 7'b1100000;  // Lower case b.
            4'hC: return 7'b0110001;
            4'hD: return 7'b1000010;  // Lower case d.
            4'hE: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    function automatic seg_t dec_digit_seg(input logic [7:0] value);
        if (value > 8'd9) begin
            return SEG_BLANK;
        end
        return hex_digit_seg(value[3:0]);
    endfunction

endpackage

/* src/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ps2_clk,
    input  logic            ps2_data,
    output ps2_pkg::code_t  rx_code,
    output logic            rx_valid
);

    logic [2:0] clk_sync;
    logic       fall;
    logic [3:0] bit_cnt;
    logic [9:0] shreg;
    logic       frame_ok;

    // Keyboard clock crosses into clk here.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync <= 3'b111;  // Line idles high.
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
        end
    end

    assign fall = clk_sync[2] & ~clk_sync[1];

    // Start low, odd parity over data and parity, stop high.
    assign frame_ok = (shreg[0] == 1'b0) && (^shreg[9:1] == 1'b1) && ps2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= 4'd0;
        end else if (fall) begin
            if (bit_cnt == 4'd10) begin
                bit_cnt <= 4'd0;  // Stop bit ends the frame.
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_cnt != 4'd10) begin
            shreg <= {ps2_data, shreg[9:1]};  // LSB arrives first.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= fall && (bit_cnt == 4'd10) && frame_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_cnt == 4'd10) begin
            rx_code <= shreg[8:1];
        end
    end

endmodule

/* src/scan_fifo.sv */
`timescale 1ns/1ps

module scan_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  ps2_pkg::code_t  push_code,
    input  logic            next_n,
    output ps2_pkg::code_t  head_code,
    output logic            ready,
    output logic            overflow
);

    localparam int IDX_W = $bits(ps2_pkg::ptr_t) - 1;

    ps2_pkg::code_t  mem [ps2_pkg::FIFO_DEPTH];
    ps2_pkg::ptr_t   wr_ptr;
    ps2_pkg::ptr_t   rd_ptr;
    ps2_pkg::ptr_t   fill;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign fill    = wr_ptr - rd_ptr;
    assign full    = (fill == ps2_pkg::ptr_t'(ps2_pkg::FIFO_DEPTH));
    assign ready   = (wr_ptr != rd_ptr);
    assign do_push = push && !full;
    assign do_pop  = ready && !next_n;  // Held low pops every cycle.

    assign head_code = mem[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 4'd1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 4'd1;
            end
            if (push && full) begin
                overflow <= 1'b1;  // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[IDX_W-1:0]] <= push_code;
        end
    end

endmodule

/* src/seg_display.sv */
`timescale 1ns/1ps

module seg_display (
    input  ps2_pkg::code_t   head_code,
    input  logic             ready,
    input  logic             key_up,
    input  ps2_pkg::count_t  press_count,
    output ps2_pkg::seg_t    seg0,
    output ps2_pkg::seg_t    seg1,
    output ps2_pkg::seg_t    seg2,
    output ps2_pkg::seg_t    seg3,
    output ps2_pkg::seg_t    seg4,
    output ps2_pkg::seg_t    seg5
);

    logic             show_code;
    ps2_pkg::code_t   code_ones;
    ps2_pkg::code_t   code_tens;
    ps2_pkg::count_t  count_ones;
    ps2_pkg::count_t  count_tens;
    ps2_pkg::seg_t    hex_lo;
    ps2_pkg::seg_t    hex_hi;
    ps2_pkg::seg_t    dec_lo;
    ps2_pkg::seg_t    dec_hi;

    assign show_code = ready && !key_up;

    assign code_ones  = head_code % 8'd10;
    assign code_tens  = head_code / 8'd10;  // Up to 25, blank above 9.
    assign count_ones = press_count % 8'd10;
    assign count_tens = press_count / 8'd10;

    assign hex_lo = ps2_pkg::hex_digit_seg(head_code[3:0]);
    assign hex_hi = ps2_pkg::hex_digit_seg(head_code[7:4]);
    assign dec_lo = ps2_pkg::dec_digit_seg(code_ones);
    assign dec_hi = ps2_pkg::dec_digit_seg(code_tens);

    // Code digits go dark while a key is up or the queue is empty.
    always_comb begin
        if (show_code) begin
            seg0 = hex_lo;
            seg1 = hex_hi;
            seg2 = dec_lo;
            seg3 = dec_hi;
        end else begin
            seg0 = ps2_pkg::SEG_BLANK;
            seg1 = ps2_pkg::SEG_BLANK;
            seg2 = ps2_pkg::SEG_BLANK;
            seg3 = ps2_pkg::SEG_BLANK;
        end
    end

    assign seg4 = ps2_pkg::dec_digit_seg(count_ones);
    assign seg5 = ps2_pkg::dec_digit_seg(count_tens);

endmodule
